//--- Makefile
# Verilator build and run of the image pipeline testbench

SIM = obj_dir/sim_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module tb_image_processing -o sim_tb

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

//--- rtl/channel_gain.sv
// one colour component: fixed-point gain, clip to full scale, threshold window
module channel_gain
    import img_pkg::*;
#(
    parameter int GAIN_FRAC = 8
) (
    input  logic      aclk,
    input  logic      rst_n_i,
    input  comp_t     s_comp_i,
    input  chan_cfg_t cfg_i,
    output comp_t     m_comp_o,
    output logic      m_in_window_o
);

    localparam int    PROD_WIDTH  = DATA_WIDTH + GAIN_WIDTH;
    localparam int    SCALE_WIDTH = PROD_WIDTH - GAIN_FRAC;
    localparam comp_t COMP_MAX    = '1;
    localparam logic [GAIN_WIDTH-1:0] GAIN_ONE = GAIN_WIDTH'(2 ** GAIN_FRAC);

    logic [PROD_WIDTH-1:0]  product;
    logic [SCALE_WIDTH-1:0] scaled;
    logic                   overflow;
    comp_t                  clipped;
    comp_t                  gain_st1;

    // --------------------
    // stage 1, gain and clip
    assign product  = PROD_WIDTH'(s_comp_i) * PROD_WIDTH'(cfg_i.gain);
    assign scaled   = product[PROD_WIDTH-1:GAIN_FRAC];
    assign overflow = |scaled[SCALE_WIDTH-1:DATA_WIDTH];
    assign clipped  = overflow ? COMP_MAX : scaled[DATA_WIDTH-1:0];

    always_ff @(posedge aclk) begin
        gain_st1 <= clipped;
    end

    // --------------------
    // stage 2, window test (limits inclusive)
    always_ff @(posedge aclk) begin
        m_comp_o      <= gain_st1;
        m_in_window_o <= (gain_st1 >= cfg_i.th_lo) && (gain_st1 <= cfg_i.th_hi);
    end

    // gains up to 1.0 never raise a component
    a_gain_le_one_no_rise : assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        (cfg_i.gain <= GAIN_ONE) |-> (clipped <= s_comp_i));

endmodule

//--- rtl/image_processing.sv
// colour pipeline top: register bank, capture, three gain channels, output select
module image_processing
    import img_pkg::*;
#(
    parameter int GAIN_FRAC = 8
) (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    input  logic                    in_update_req_i,
    input  logic [WB_ADR_WIDTH-1:0] s_wb_adr_i,
    input  logic [WB_DAT_WIDTH-1:0] s_wb_dat_i,
    input  logic                    s_wb_we_i,
    input  logic                    s_wb_stb_i,
    output logic [WB_DAT_WIDTH-1:0] s_wb_dat_o,
    output logic                    s_wb_ack_o,
    input  pix_flags_t              s_img_flags_i,
    input  rgb_t                    s_img_rgb_i,
    output pix_flags_t              m_img_flags_o,
    output out_pix_t                m_img_data_o
);

    chan_cfg_t [2:0] chan_cfg;
    sel_mode_e       sel_mode;
    logic            update;
    pix_flags_t      cap_flags;
    rgb_t            cap_rgb;
    comp_t [2:0]     cap_comp;
    comp_t [2:0]     gain_comp;
    rgb_t            gain_rgb;
    logic [2:0]      in_window;

    wb_regs #(
        .GAIN_FRAC (GAIN_FRAC)
    ) i_wb_regs (
        .aclk       (aclk),
        .rst_n_i    (rst_n_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_ack_o (s_wb_ack_o),
        .update_i   (update),
        .chan_cfg_o (chan_cfg),
        .sel_mode_o (sel_mode)
    );

    pixel_capture i_pixel_capture (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .in_update_req_i (in_update_req_i),
        .s_flags_i       (s_img_flags_i),
        .s_rgb_i         (s_img_rgb_i),
        .m_flags_o       (cap_flags),
        .m_rgb_o         (cap_rgb),
        .update_o        (update)
    );

    // --------------------
    // channel 0 r, 1 g, 2 b
    assign cap_comp = {cap_rgb.b, cap_rgb.g, cap_rgb.r};
    assign gain_rgb = '{r: gain_comp[0], g: gain_comp[1], b: gain_comp[2]};

    for (genvar ch = 0; ch < 3; ch++) begin : g_chan
        channel_gain #(
            .GAIN_FRAC (GAIN_FRAC)
        ) i_channel_gain (
            .aclk          (aclk),
            .rst_n_i       (rst_n_i),
            .s_comp_i      (cap_comp[ch]),
            .cfg_i         (chan_cfg[ch]),
            .m_comp_o      (gain_comp[ch]),
            .m_in_window_o (in_window[ch])
        );
    end

    output_select i_output_select (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .s_flags_i     (cap_flags),
        .s_rgb_i       (cap_rgb),
        .s_gain_i      (gain_rgb),
        .s_in_window_i (in_window),
        .sel_mode_i    (sel_mode),
        .m_flags_o     (m_img_flags_o),
        .m_data_o      (m_img_data_o)
    );

endmodule

//--- rtl/img_pkg.sv
// widths, pixel and settings structs, select and register address enums
package img_pkg;

    localparam int DATA_WIDTH   = 10;
    localparam int OUT_WIDTH    = 8;
    localparam int GAIN_WIDTH   = 16;
    localparam int WB_ADR_WIDTH = 8;
    localparam int WB_DAT_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] comp_t;

    // frame position flags, travel with every pixel
    typedef struct packed {
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
        logic de;
        logic valid;
    } pix_flags_t;

    typedef struct packed {
        comp_t r;
        comp_t g;
        comp_t b;
    } rgb_t;

    typedef struct packed {
        logic [GAIN_WIDTH-1:0] gain;
        comp_t                 th_lo;
        comp_t                 th_hi;
    } chan_cfg_t;

    // byte 0 blue, 1 green, 2 red, 3 zero
    typedef logic [3:0][OUT_WIDTH-1:0] out_pix_t;

    typedef enum logic [1:0] {
        SEL_SOURCE = 2'd0,
        SEL_GAIN   = 2'd1,
        SEL_BINARY = 2'd2
    } sel_mode_e;

    typedef enum logic [WB_ADR_WIDTH-1:0] {
        REG_GAIN_R  = 8'h00,
        REG_GAIN_G  = 8'h01,
        REG_GAIN_B  = 8'h02,
        REG_TH_LO_R = 8'h04,
        REG_TH_LO_G = 8'h05,
        REG_TH_LO_B = 8'h06,
        REG_TH_HI_R = 8'h08,
        REG_TH_HI_G = 8'h09,
        REG_TH_HI_B = 8'h0A,
        REG_SELECT  = 8'h10
    } reg_addr_e;

endpackage

//--- rtl/output_select.sv
// flag and source alignment, mask combine, mode select and output byte packing
module output_select
    import img_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  pix_flags_t s_flags_i,
    input  rgb_t       s_rgb_i,
    input  rgb_t       s_gain_i,
    input  logic [2:0] s_in_window_i,
    input  sel_mode_e  sel_mode_i,
    output pix_flags_t m_flags_o,
    output out_pix_t   m_data_o
);

    pix_flags_t flags_d1;
    pix_flags_t flags_d2;
    rgb_t       src_d1;
    rgb_t       src_d2;
    sel_mode_e  mode_d1;
    sel_mode_e  mode_d2;
    logic       bin_mask;
    out_pix_t   data_next;

    // top bits of each component, b g r 0
    function automatic out_pix_t pack_rgb(input rgb_t pix);
        out_pix_t word;
        word[0] = pix.b[DATA_WIDTH-1 -: OUT_WIDTH];
        word[1] = pix.g[DATA_WIDTH-1 -: OUT_WIDTH];
        word[2] = pix.r[DATA_WIDTH-1 -: OUT_WIDTH];
        word[3] = '0;
        return word;
    endfunction

    // --------------------
    // two-cycle delay to meet the channel outputs
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flags_d1 <= '0;
            flags_d2 <= '0;
            mode_d1  <= SEL_GAIN;
            mode_d2  <= SEL_GAIN;
        end else begin
            flags_d1 <= s_flags_i;
            flags_d2 <= flags_d1;
            mode_d1  <= sel_mode_i;
            mode_d2  <= mode_d1;
        end
    end

    always_ff @(posedge aclk) begin
        src_d1 <= s_rgb_i;
        src_d2 <= src_d1;
    end

    // --------------------
    // select and pack
    assign bin_mask = &s_in_window_i;

    always_comb begin
        case (mode_d2)
            SEL_SOURCE: data_next = pack_rgb(src_d2);
            SEL_GAIN:   data_next = pack_rgb(s_gain_i);
            SEL_BINARY: data_next = {(4 * OUT_WIDTH){bin_mask}};
            default:    data_next = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_flags_o <= '0;
        end else begin
            m_flags_o <= flags_d2;
        end
    end

    always_ff @(posedge aclk) begin
        m_data_o <= data_next;
    end

    // mode in effect for a valid output pixel is a defined one
    a_mode_legal : assert property (
        @(posedge aclk) disable iff (!rst_n_i)
        flags_d2.valid |-> (mode_d2 inside {SEL_SOURCE, SEL_GAIN, SEL_BINARY}));

endmodule

//--- rtl/pixel_capture.sv
// input pixel register and frame-start update request tracking
module pixel_capture
    import img_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  logic       in_update_req_i,
    input  pix_flags_t s_flags_i,
    input  rgb_t       s_rgb_i,
    output pix_flags_t m_flags_o,
    output rgb_t       m_rgb_o,
    output logic       update_o
);

    logic pending;
    logic frame_start;

    // first active pixel of a frame
    assign frame_start = s_flags_i.valid && s_flags_i.de
                      && s_flags_i.row_first && s_flags_i.col_first;

    // a request seen on the same edge still counts
    assign update_o = frame_start && (pending || in_update_req_i);

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending <= 1'b0;
        end else if (update_o) begin
            pending <= 1'b0;
        end else if (in_update_req_i) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_flags_o <= '0;
        end else begin
            m_flags_o <= s_flags_i;
        end
    end

    always_ff @(posedge aclk) begin
        m_rgb_o <= s_rgb_i;
    end

endmodule

//--- rtl/wb_regs.sv
// wishbone register bank: shadow settings, address decode, active copy on update
module wb_regs
    import img_pkg::*;
#(
    parameter int GAIN_FRAC = 8
) (
    input  logic                    aclk,
    input  logic                    rst_n_i,
    input  logic [WB_ADR_WIDTH-1:0] s_wb_adr_i,
    input  logic [WB_DAT_WIDTH-1:0] s_wb_dat_i,
    input  logic                    s_wb_we_i,
    input  logic                    s_wb_stb_i,
    output logic [WB_DAT_WIDTH-1:0] s_wb_dat_o,
    output logic                    s_wb_ack_o,
    input  logic                    update_i,
    output chan_cfg_t [2:0]         chan_cfg_o,
    output sel_mode_e               sel_mode_o
);

    localparam logic [GAIN_WIDTH-1:0] GAIN_ONE = GAIN_WIDTH'(2 ** GAIN_FRAC);
    localparam chan_cfg_t CFG_RST = '{gain: GAIN_ONE, th_lo: '0, th_hi: '1};

    chan_cfg_t [2:0] shadow_cfg;
    sel_mode_e       shadow_sel;
    reg_addr_e       wb_addr;

    assign wb_addr    = reg_addr_e'(s_wb_adr_i);
    assign s_wb_ack_o = s_wb_stb_i;

    // --------------------
    // shadow write
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shadow_cfg <= {3{CFG_RST}};
            shadow_sel <= SEL_GAIN;
        end else if (s_wb_stb_i && s_wb_we_i) begin
            case (wb_addr)
                REG_GAIN_R:  shadow_cfg[0].gain  <= s_wb_dat_i[GAIN_WIDTH-1:0];
                REG_GAIN_G:  shadow_cfg[1].gain  <= s_wb_dat_i[GAIN_WIDTH-1:0];
                REG_GAIN_B:  shadow_cfg[2].gain  <= s_wb_dat_i[GAIN_WIDTH-1:0];
                REG_TH_LO_R: shadow_cfg[0].th_lo <= s_wb_dat_i[DATA_WIDTH-1:0];
                REG_TH_LO_G: shadow_cfg[1].th_lo <= s_wb_dat_i[DATA_WIDTH-1:0];
                REG_TH_LO_B: shadow_cfg[2].th_lo <= s_wb_dat_i[DATA_WIDTH-1:0];
                REG_TH_HI_R: shadow_cfg[0].th_hi <= s_wb_dat_i[DATA_WIDTH-1:0];
                REG_TH_HI_G: shadow_cfg[1].th_hi <= s_wb_dat_i[DATA_WIDTH-1:0];
                REG_TH_HI_B: shadow_cfg[2].th_hi <= s_wb_dat_i[DATA_WIDTH-1:0];
                REG_SELECT:  shadow_sel          <= sel_mode_e'(s_wb_dat_i[1:0]);
                default: ;
            endcase
        end
    end

    // read back shadow, unmapped reads zero
    always_comb begin
        s_wb_dat_o = '0;
        case (wb_addr)
            REG_GAIN_R:  s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[0].gain);
            REG_GAIN_G:  s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[1].gain);
            REG_GAIN_B:  s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[2].gain);
            REG_TH_LO_R: s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[0].th_lo);
            REG_TH_LO_G: s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[1].th_lo);
            REG_TH_LO_B: s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[2].th_lo);
            REG_TH_HI_R: s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[0].th_hi);
            REG_TH_HI_G: s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[1].th_hi);
            REG_TH_HI_B: s_wb_dat_o = WB_DAT_WIDTH'(shadow_cfg[2].th_hi);
            REG_SELECT:  s_wb_dat_o = WB_DAT_WIDTH'(shadow_sel);
            default:     s_wb_dat_o = '0;
        endcase
    end

    // --------------------
    // active set, loaded at frame start
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            chan_cfg_o <= {3{CFG_RST}};
            sel_mode_o <= SEL_GAIN;
        end else if (update_i) begin
            chan_cfg_o <= shadow_cfg;
            sel_mode_o <= shadow_sel;
        end
    end

    a_ack_needs_stb : assert property (
        @(posedge aclk) disable iff (!rst_n_i) s_wb_ack_o |-> s_wb_stb_i);

endmodule

//--- tb.f
+incdir+verification
rtl/img_pkg.sv
rtl/wb_regs.sv
rtl/pixel_capture.sv
rtl/channel_gain.sv
rtl/output_select.sv
rtl/image_processing.sv
verification/tb_image_processing.sv

//--- verification/tb_checks.svh
// pixel and wishbone driver tasks, typed compare tasks for flags, pixels and bus words
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// compare tasks
task automatic check_flags(input string name, input pix_flags_t got, input pix_flags_t exp);
    if (got !== exp) begin
        stop_with_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_pixel(input string name, input out_pix_t got, input out_pix_t exp);
    if (got !== exp) begin
        stop_with_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_word(input string name, input logic [WB_DAT_WIDTH-1:0] got,
                          input logic [WB_DAT_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_with_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

// --------------------
// wishbone
task automatic wb_write(input logic [WB_ADR_WIDTH-1:0] adr, input logic [WB_DAT_WIDTH-1:0] data);
    @(posedge aclk);
    #DRIVE_DELAY;
    s_wb_adr_i = adr;
    s_wb_dat_i = data;
    s_wb_we_i  = 1'b1;
    s_wb_stb_i = 1'b1;
    #1;
    if (s_wb_ack_o !== 1'b1) begin
        stop_with_error($sformatf("no wishbone ack for a write to address %h", adr));
    end
    @(posedge aclk);
    model_write(adr, data);
    #DRIVE_DELAY;
    s_wb_stb_i = 1'b0;
    s_wb_we_i  = 1'b0;
endtask

task automatic wb_read_check(input logic [WB_ADR_WIDTH-1:0] adr,
                             input logic [WB_DAT_WIDTH-1:0] exp);
    @(posedge aclk);
    #DRIVE_DELAY;
    s_wb_adr_i = adr;
    s_wb_we_i  = 1'b0;
    s_wb_stb_i = 1'b1;
    #1;
    if (s_wb_ack_o !== 1'b1) begin
        stop_with_error($sformatf("no wishbone ack for a read of address %h", adr));
    end
    check_word("s_wb_dat_o", s_wb_dat_o, exp);
    @(posedge aclk);
    #DRIVE_DELAY;
    s_wb_stb_i = 1'b0;
    #1;
    if (s_wb_ack_o !== 1'b0) begin
        stop_with_error("wishbone ack stayed high after stb was released");
    end
endtask

// one cycle request, pixel input idle
task automatic request_update();
    @(posedge aclk);
    #DRIVE_DELAY;
    in_update_req_i = 1'b1;
    pending = 1'b1;
    @(posedge aclk);
    #DRIVE_DELAY;
    in_update_req_i = 1'b0;
endtask

// --------------------
// pixel stream
// checks the output of the pixel sent four cycles back, then drives the next one
task automatic drive_pixel(input pix_flags_t f, input rgb_t pix);
    exp_pix_t head;
    exp_pix_t entry;
    @(posedge aclk);
    #DRIVE_DELAY;
    head = exp_q.pop_front();
    check_flags("m_img_flags_o", m_img_flags_o, head.flags);
    if (head.flags.valid) begin
        check_pixel("m_img_data_o", m_img_data_o, head.data);
    end
    s_img_flags_i = f;
    s_img_rgb_i   = pix;
    if (f.valid && f.de && f.row_first && f.col_first && pending) begin
        act_cfg = sh_cfg;
        act_sel = sh_sel;
        pending = 1'b0;
    end
    entry.flags = f;
    entry.data  = expected_pixel(pix);
    exp_q.push_back(entry);
endtask

task automatic flush_pipeline();
    repeat (6) drive_pixel('0, '0);
endtask

task automatic send_frame(input int rows, input int cols, input logic with_start,
                          input logic with_gaps);
    pix_flags_t  f;
    logic [31:0] rnd;
    for (int r = 0; r < rows; r++) begin
        for (int c = 0; c < cols; c++) begin
            while (with_gaps && (($random(seed) & 3) == 0)) begin
                drive_pixel('0, '0);
            end
            f = '{row_first: with_start && (r == 0), row_last: (r == rows - 1),
                  col_first: (c == 0), col_last: (c == cols - 1),
                  de: 1'b1, valid: 1'b1};
            rnd = $random(seed);
            drive_pixel(f, rnd[29:0]);
        end
    end
    flush_pipeline();
endtask

`endif

//--- verification/tb_image_processing.sv
// testbench top: clock, reset, watchdog, DUT, reference model and directed tests
module tb_image_processing
    import img_pkg::*;
();

    localparam int GAIN_FRAC   = 8;
    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int ROWS        = 4;
    localparam int COLS        = 6;
    localparam int FRAMES      = 5;
    localparam int BUS_OPS     = 64;
    // reset, frames with up to one gap per pixel, two cycles per bus access
    localparam int RUN_CYCLES    = 10 + FRAMES * ROWS * COLS * 2 + BUS_OPS * 2;
    localparam int WATCHDOG_TIME = (RUN_CYCLES + 200) * CLK_PERIOD;

    typedef struct packed {
        pix_flags_t flags;
        out_pix_t   data;
    } exp_pix_t;

    logic                    aclk;
    logic                    rst_n_i;
    logic                    in_update_req_i;
    logic [WB_ADR_WIDTH-1:0] s_wb_adr_i;
    logic [WB_DAT_WIDTH-1:0] s_wb_dat_i;
    logic                    s_wb_we_i;
    logic                    s_wb_stb_i;
    logic [WB_DAT_WIDTH-1:0] s_wb_dat_o;
    logic                    s_wb_ack_o;
    pix_flags_t              s_img_flags_i;
    rgb_t                    s_img_rgb_i;
    pix_flags_t              m_img_flags_o;
    out_pix_t                m_img_data_o;

    integer          seed;
    chan_cfg_t [2:0] sh_cfg;
    chan_cfg_t [2:0] act_cfg;
    sel_mode_e       sh_sel;
    sel_mode_e       act_sel;
    logic            pending;
    exp_pix_t        exp_q[$];

    image_processing #(
        .GAIN_FRAC (GAIN_FRAC)
    ) dut_i (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .in_update_req_i (in_update_req_i),
        .s_wb_adr_i      (s_wb_adr_i),
        .s_wb_dat_i      (s_wb_dat_i),
        .s_wb_we_i       (s_wb_we_i),
        .s_wb_stb_i      (s_wb_stb_i),
        .s_wb_dat_o      (s_wb_dat_o),
        .s_wb_ack_o      (s_wb_ack_o),
        .s_img_flags_i   (s_img_flags_i),
        .s_img_rgb_i     (s_img_rgb_i),
        .m_img_flags_o   (m_img_flags_o),
        .m_img_data_o    (m_img_data_o)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_TIME);
        stop_with_error("watchdog timeout, the tests did not finish in time");
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_checks.svh"

    // --------------------
    // reference model
    function automatic comp_t apply_gain(input comp_t c, input logic [GAIN_WIDTH-1:0] gain);
        logic [31:0] scaled;
        scaled = (32'(c) * 32'(gain)) >> GAIN_FRAC;
        return (scaled > 32'd1023) ? 10'h3FF : scaled[DATA_WIDTH-1:0];
    endfunction

    function automatic logic in_window(input comp_t v, input chan_cfg_t cfg);
        return (v >= cfg.th_lo) && (v <= cfg.th_hi);
    endfunction

    function automatic out_pix_t expected_pixel(input rgb_t pix);
        comp_t gr;
        comp_t gg;
        comp_t gb;
        logic  mask;
        gr = apply_gain(pix.r, act_cfg[0].gain);
        gg = apply_gain(pix.g, act_cfg[1].gain);
        gb = apply_gain(pix.b, act_cfg[2].gain);
        mask = in_window(gr, act_cfg[0]) && in_window(gg, act_cfg[1])
            && in_window(gb, act_cfg[2]);
        case (act_sel)
            SEL_SOURCE: return {8'h00, pix.r[9:2], pix.g[9:2], pix.b[9:2]};
            SEL_GAIN:   return {8'h00, gr[9:2], gg[9:2], gb[9:2]};
            SEL_BINARY: return mask ? 32'hFFFF_FFFF : 32'h0000_0000;
            default:    return '0;
        endcase
    endfunction

    // low two address bits pick the channel within each register group
    function automatic void model_write(input logic [7:0] adr, input logic [31:0] data);
        case (adr)
            8'h00, 8'h01, 8'h02: sh_cfg[adr[1:0]].gain  = data[15:0];
            8'h04, 8'h05, 8'h06: sh_cfg[adr[1:0]].th_lo = data[9:0];
            8'h08, 8'h09, 8'h0A: sh_cfg[adr[1:0]].th_hi = data[9:0];
            8'h10:               sh_sel = sel_mode_e'(data[1:0]);
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] adr);
        case (adr)
            8'h00, 8'h01, 8'h02: return 32'(sh_cfg[adr[1:0]].gain);
            8'h04, 8'h05, 8'h06: return 32'(sh_cfg[adr[1:0]].th_lo);
            8'h08, 8'h09, 8'h0A: return 32'(sh_cfg[adr[1:0]].th_hi);
            8'h10:               return 32'(sh_sel);
            default:             return 32'h0;
        endcase
    endfunction

    // --------------------
    // directed tests
    task automatic test_reset_state();
        reg_addr_e a;
        a = a.first();
        repeat (a.num()) begin
            wb_read_check(a, model_read(a));
            a = a.next();
        end
        flush_pipeline();
        send_frame(ROWS, COLS, 1'b1, 1'b0);
    endtask

    task automatic test_register_access();
        reg_addr_e   a;
        logic [31:0] val;
        a = a.first();
        repeat (a.num()) begin
            val = (a == REG_SELECT) ? 32'hFFFF_FFFE : {16'hA5C3, 16'h0155 + 16'(a) * 16'h0011};
            wb_write(a, val);
            a = a.next();
        end
        a = a.first();
        repeat (a.num()) begin
            wb_read_check(a, model_read(a));
            a = a.next();
        end
        wb_read_check(8'h03, 32'h0);
        wb_read_check(8'h7F, 32'h0);
    endtask

    task automatic test_gain_clip();
        // red at 4.5 clips above 227
        wb_write(REG_GAIN_R, 32'h0480);
        wb_write(REG_GAIN_G, 32'h00C0);
        wb_write(REG_GAIN_B, 32'h0200);
        for (int ch = 0; ch < 3; ch++) begin
            wb_write(8'(REG_TH_LO_R) + 8'(ch), 32'h0);
            wb_write(8'(REG_TH_HI_R) + 8'(ch), 32'h3FF);
        end
        wb_write(REG_SELECT, 32'(SEL_GAIN));
        request_update();
        send_frame(2, COLS, 1'b0, 1'b0);
        send_frame(ROWS, COLS, 1'b1, 1'b0);
    endtask

    task automatic test_binary_mask();
        // gain of 1.25 so the window sees gained values, not source values
        for (int ch = 0; ch < 3; ch++) begin
            wb_write(8'(REG_GAIN_R) + 8'(ch), 32'h0140);
            wb_write(8'(REG_TH_LO_R) + 8'(ch), 32'h040);
            wb_write(8'(REG_TH_HI_R) + 8'(ch), 32'h380);
        end
        wb_write(REG_SELECT, 32'(SEL_BINARY));
        request_update();
        send_frame(ROWS, COLS, 1'b1, 1'b0);
    endtask

    task automatic test_source_flags();
        wb_write(REG_SELECT, 32'(SEL_SOURCE));
        request_update();
        send_frame(ROWS, COLS, 1'b1, 1'b1);
    endtask

    initial begin
        exp_pix_t idle_exp;
        seed            = 79;
        rst_n_i         = 1'b0;
        in_update_req_i = 1'b0;
        s_wb_adr_i      = '0;
        s_wb_dat_i      = '0;
        s_wb_we_i       = 1'b0;
        s_wb_stb_i      = 1'b0;
        s_img_flags_i   = '0;
        s_img_rgb_i     = '0;
        for (int ch = 0; ch < 3; ch++) begin
            sh_cfg[ch] = '{gain: 16'(1 << GAIN_FRAC), th_lo: 10'h000, th_hi: 10'h3FF};
        end
        sh_sel   = SEL_GAIN;
        act_cfg  = sh_cfg;
        act_sel  = sh_sel;
        pending  = 1'b0;
        idle_exp = '0;
        repeat (4) exp_q.push_back(idle_exp);

        repeat (10) @(posedge aclk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        test_reset_state();
        test_register_access();
        test_gain_clip();
        test_binary_mask();
        test_source_flags();

        $display("Simulation passed");
        $finish;
    end

endmodule
